// File: logic/perf_latency.sv
`timescale 1ns/1ps
`default_nettype none

module perf_latency #(
	parameter int lat_width = 16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 clear,
	input  logic                 sample,
	input  logic [lat_width-1:0] cycles,
	output logic [lat_width-1:0] min,
	output logic [lat_width-1:0] max
);

	logic take_min;
	logic take_max;

	// zero minimum means nothing seen yet.
	assign take_min = sample && (min == '0 || cycles < min);
	assign take_max = sample && cycles >= max;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			min <= '0;
			max <= '0;
		end else if (clear) begin
			min <= '0;
			max <= '0;
		end else begin
			if (take_min)
				min <= cycles;
			if (take_max)
				max <= cycles;
		end
	end

endmodule

`default_nettype wire

// File: logic/perf_link.sv
`timescale 1ns/1ps
`default_nettype none

module perf_link #(
	parameter int lat_width = 16
) (
	input  logic             clk,
	input  logic             rst_n,

	input  logic             in_left_valid,
	input  perf_pkg::ring_req in_left,
	output logic             in_left_ready,

	input  logic             in_right_valid,
	input  perf_pkg::ring_req in_right,
	output logic             in_right_ready,

	input  logic             out_left_ready,
	output perf_pkg::ring_req out_left,
	output logic             out_left_valid,

	input  perf_pkg::line_ptr local_address,
	input  logic             local_read,
	input  logic             local_write,
	input  perf_pkg::line    local_writedata,
	input  perf_pkg::line_be local_byteenable,
	output logic             local_waitrequest,
	output perf_pkg::line    local_readdata,

	input  logic             mem_waitrequest,
	input  perf_pkg::line    mem_readdata,
	output perf_pkg::word    mem_address,
	output logic             mem_read,
	output logic             mem_write,
	output perf_pkg::line    mem_writedata,
	output perf_pkg::line_be mem_byteenable,

	input  logic             clear,
	input  logic [3:0]       address,
	output perf_pkg::word    readdata
);
	import perf_pkg::*;

	logic mem_done, cached, left_take, right_take, ring_end, ring_new;

	logic [lat_width-1:0] mem_cycles, mem_cycles_hold, ring_cycles;
	logic [lat_width-1:0] read_min, read_max, write_min, write_max, ring_min, ring_max;

	word reads, writes, io_reads, io_writes, ring_reads, ring_invals, ring_read_invals,
	     ring_replies, ring_forwards;

	snoop_if tap ();

	perf_snoop snoop_i (
		.tap (tap),
		.*
	);

	// ******************************
	// event decode
	// ******************************

	assign mem_done   = (tap.read || tap.write) && !tap.waitrequest;
	assign cached     = tap.address.bits.io == IO_CACHED;
	assign mem_cycles = mem_cycles_hold + 1'b1; // includes this cycle.
	assign left_take  = tap.left_valid && tap.left_ready;
	assign right_take = tap.right_valid && tap.right_ready;
	assign ring_end   = left_take && tap.left.ttl == TTL_END;
	assign ring_new   = right_take && tap.right.ttl == TTL_MAX;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_cycles_hold <= '0;
			ring_cycles     <= '0;
		end else begin
			if (mem_done)
				mem_cycles_hold <= '0;
			else if (tap.read || tap.write)
				mem_cycles_hold <= mem_cycles;

			// latest injection restarts the round trip.
			ring_cycles <= ring_new ? lat_width'(1) : ring_cycles + 1'b1;
		end
	end

	// ******************************
	// event counters
	// ******************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reads            <= '0;
			writes           <= '0;
			io_reads         <= '0;
			io_writes        <= '0;
			ring_reads       <= '0;
			ring_invals      <= '0;
			ring_read_invals <= '0;
			ring_replies     <= '0;
			ring_forwards    <= '0;
		end else if (clear) begin
			reads            <= '0;
			writes           <= '0;
			io_reads         <= '0;
			io_writes        <= '0;
			ring_reads       <= '0;
			ring_invals      <= '0;
			ring_read_invals <= '0;
			ring_replies     <= '0;
			ring_forwards    <= '0;
		end else begin
			if (mem_done) begin
				if (!cached && tap.write)
					io_writes <= io_writes + 1;
				else if (!cached)
					io_reads <= io_reads + 1;
				else if (tap.write)
					writes <= writes + 1;
				else
					reads <= reads + 1;
			end

			if (ring_end && tap.left.reply)
				ring_replies <= ring_replies + 1;

			if (ring_new) begin
				if (tap.right.read && !tap.right.inval)
					ring_reads <= ring_reads + 1;
				if (!tap.right.read && tap.right.inval)
					ring_invals <= ring_invals + 1;
				if (tap.right.read && tap.right.inval)
					ring_read_invals <= ring_read_invals + 1;
			end else if (right_take) begin
				ring_forwards <= ring_forwards + 1; // passing through.
			end
		end
	end

	perf_latency #(.lat_width(lat_width)) read_lat_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.clear  (clear),
		.sample (mem_done && cached && !tap.write),
		.cycles (mem_cycles),
		.min    (read_min),
		.max    (read_max)
	);

	perf_latency #(.lat_width(lat_width)) write_lat_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.clear  (clear),
		.sample (mem_done && cached && tap.write),
		.cycles (mem_cycles),
		.min    (write_min),
		.max    (write_max)
	);

	perf_latency #(.lat_width(lat_width)) ring_lat_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.clear  (clear),
		.sample (ring_end),
		.cycles (ring_cycles),
		.min    (ring_min),
		.max    (ring_max)
	);

	// ******************************
	// register window
	// ******************************

	always_comb begin
		unique case (address)
			4'd0:    readdata = reads;
			4'd1:    readdata = writes;
			4'd2:    readdata = {hword'(read_max), hword'(read_min)};
			4'd3:    readdata = {hword'(write_max), hword'(write_min)};
			4'd4:    readdata = ring_reads;
			4'd5:    readdata = ring_invals;
			4'd6:    readdata = ring_read_invals;
			4'd7:    readdata = ring_replies;
			4'd8:    readdata = ring_forwards;
			4'd9:    readdata = {hword'(ring_max), hword'(ring_min)};
			4'd10:   readdata = io_reads;
			4'd11:   readdata = io_writes;
			default: readdata = '0; // unused slots.
		endcase
	end

endmodule

`default_nettype wire

// File: logic/perf_pkg.sv
`default_nettype none

package perf_pkg;

	// ******************************
	// basic data types
	// ******************************

	typedef logic [31:0]  word;
	typedef logic [15:0]  hword;
	typedef logic [127:0] line;
	typedef logic [15:0]  line_be;
	typedef logic [27:0]  line_ptr; // word address without offset.

	typedef struct packed {
		logic [1:0]  io;       // memory region, 0 is cached.
		logic [25:0] line_idx;
		logic [3:0]  offset;
	} addr_bits;

	typedef union packed {
		word      raw;
		addr_bits bits;
	} ring_addr;

	// ******************************
	// ring messages
	// ******************************

	typedef struct packed {
		logic       read;
		logic       inval;
		logic       reply;
		logic [1:0] ttl;
		ring_addr   addr;
	} ring_req;

	// fields the counters look at.
	typedef struct packed {
		logic       read;
		logic       inval;
		logic       reply;
		logic [1:0] ttl;
	} perf_sample;

	localparam logic [1:0] IO_CACHED = 2'd0;
	localparam logic [1:0] TTL_MAX   = 2'd3; // fresh injection.
	localparam logic [1:0] TTL_END   = 2'd0; // back home.

endpackage

`default_nettype wire

// File: logic/perf_snoop.sv
`timescale 1ns/1ps
`default_nettype none

module perf_snoop (
	input  logic             clk,
	input  logic             rst_n,

	input  logic             in_left_valid,
	input  perf_pkg::ring_req in_left,
	output logic             in_left_ready,

	input  logic             in_right_valid,
	input  perf_pkg::ring_req in_right,
	output logic             in_right_ready,

	input  logic             out_left_ready,
	output perf_pkg::ring_req out_left,
	output logic             out_left_valid,

	input  perf_pkg::line_ptr local_address,
	input  logic             local_read,
	input  logic             local_write,
	input  perf_pkg::line    local_writedata,
	input  perf_pkg::line_be local_byteenable,
	output logic             local_waitrequest,
	output perf_pkg::line    local_readdata,

	input  logic             mem_waitrequest,
	input  perf_pkg::line    mem_readdata,
	output perf_pkg::word    mem_address,
	output logic             mem_read,
	output logic             mem_write,
	output perf_pkg::line    mem_writedata,
	output perf_pkg::line_be mem_byteenable,

	snoop_if.snoop           tap
);
	import perf_pkg::*;

	logic     slot_free;
	ring_addr mem_addr;

	// ******************************
	// ring forwarding stage
	// ******************************

	assign slot_free      = !out_left_valid || out_left_ready;
	assign in_right_ready = slot_free;
	assign in_left_ready  = slot_free && !in_right_valid; // right wins.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_left_valid <= 1'b0;
		else if (slot_free)
			out_left_valid <= in_right_valid || in_left_valid;
	end

	always_ff @(posedge clk) begin
		if (slot_free) begin
			if (in_right_valid)
				out_left <= in_right;
			else if (in_left_valid)
				out_left <= in_left;
		end
	end

	// ******************************
	// memory pass-through
	// ******************************

	assign mem_addr.raw      = {local_address, 4'b0000}; // line aligned.
	assign mem_address       = mem_addr.raw;
	assign mem_read          = local_read;
	assign mem_write         = local_write;
	assign mem_writedata     = local_writedata;
	assign mem_byteenable    = local_byteenable;
	assign local_waitrequest = mem_waitrequest;
	assign local_readdata    = mem_readdata;

	// taps for the counters.
	assign tap.left_valid  = in_left_valid;
	assign tap.left_ready  = in_left_ready;
	assign tap.left        = '{read: in_left.read, inval: in_left.inval,
	                           reply: in_left.reply, ttl: in_left.ttl};
	assign tap.right_valid = in_right_valid;
	assign tap.right_ready = in_right_ready;
	assign tap.right       = '{read: in_right.read, inval: in_right.inval,
	                           reply: in_right.reply, ttl: in_right.ttl};
	assign tap.read        = local_read;
	assign tap.write       = local_write;
	assign tap.waitrequest = mem_waitrequest;
	assign tap.address     = mem_addr;

endmodule

`default_nettype wire

// File: logic/snoop_if.sv
`timescale 1ns/1ps
`default_nettype none

interface snoop_if;
	import perf_pkg::*;

	logic       left_valid;
	logic       left_ready;
	perf_sample left;

	logic       right_valid;
	logic       right_ready;
	perf_sample right;

	logic       read;
	logic       write;
	logic       waitrequest;
	ring_addr   address;

	modport snoop (
		output left_valid, left_ready, left,
		output right_valid, right_ready, right,
		output read, write, waitrequest, address
	);

	modport monitor (
		input left_valid, left_ready, left,
		input right_valid, right_ready, right,
		input read, write, waitrequest, address
	);

endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the perf_link testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module perf_link_tb -o perf_link_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/perf_link_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "SIMULATION PASSED" sim.log; then
	exit 0
else
	echo "pass line not found in sim.log"
	exit 1
fi

// File: verif/perf_clock.sv
`timescale 1ns/1ps
`default_nettype none

module perf_clock #(
	parameter int period       = 20,
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1; // released on a rising edge.
	end

endmodule

`default_nettype wire

// File: verif/perf_link_assert.sv
`timescale 1ns/1ps
`default_nettype none

module perf_link_assert (
	input logic              clk,
	input logic              rst_n,
	input logic              clear,
	input logic              in_right_valid,
	input logic              in_right_ready,
	input perf_pkg::ring_req in_right,
	input logic              out_left_valid,
	input logic              out_left_ready,
	input perf_pkg::ring_req out_left,
	input perf_pkg::word     reads,
	input perf_pkg::word     ring_forwards
);

	// stalled slot keeps its message.
	hold_slot: assert property (@(posedge clk) disable iff (!rst_n)
		out_left_valid && !out_left_ready |=> out_left_valid && $stable(out_left))
		else $error("out_left changed while stalled");

	// accepted right message fills the slot.
	right_lands: assert property (@(posedge clk) disable iff (!rst_n)
		in_right_valid && in_right_ready |=> out_left_valid && out_left == $past(in_right))
		else $error("in_right message missing from out_left");

	reset_state: assert property (@(posedge clk)
		!rst_n |-> !out_left_valid && reads == '0)
		else $error("outputs not idle during reset");

	clear_zero: assert property (@(posedge clk) disable iff (!rst_n)
		clear |=> reads == '0 && ring_forwards == '0)
		else $error("counters not zero after clear");

endmodule

`default_nettype wire

// File: verif/perf_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module perf_link_tb;
	import perf_pkg::*;

	localparam int WARM_CYCLES = 300;
	localparam int RAND_CYCLES = 3000;
	localparam int STIM_CYCLES = WARM_CYCLES + RAND_CYCLES + 3 * 16 + 100; // plus drains.
	localparam int LIMIT       = 4 * STIM_CYCLES;

	logic clk, rst_n;
	logic in_left_valid, in_left_ready, in_right_valid, in_right_ready;
	logic out_left_ready, out_left_valid;
	ring_req in_left, in_right, out_left;
	line_ptr local_address;
	logic local_read, local_write, local_waitrequest;
	line local_writedata, local_readdata, mem_readdata, mem_writedata;
	line_be local_byteenable, mem_byteenable;
	logic mem_waitrequest, mem_read, mem_write;
	word mem_address;
	logic clear;
	logic [3:0] address;
	word readdata;

	int seed = 36;
	int unsigned tick = 0;

	// ******************************
	// reference model state
	// ******************************
	ring_req out_q[$];
	bit r_take, l_take, mem_done, injected;
	word m_reads, m_writes, m_io_reads, m_io_writes, m_forwards, m_replies;
	word m_ring_reads, m_ring_invals, m_ring_read_invals;
	hword rd_min, rd_max, wr_min, wr_max, rg_min, rg_max, mem_cnt, ring_cnt;

	perf_clock #(.period(20), .reset_cycles(2)) clock_i (.clk(clk), .rst_n(rst_n));

	perf_link #(.lat_width(16)) perf_link_i (.*);

	bind perf_link perf_link_assert perf_link_assert_i (
		.clk(clk), .rst_n(rst_n), .clear(clear), .in_right_valid(in_right_valid),
		.in_right_ready(in_right_ready), .in_right(in_right),
		.out_left_valid(out_left_valid), .out_left_ready(out_left_ready),
		.out_left(out_left), .reads(reads), .ring_forwards(ring_forwards)
	);

	task automatic stop_run();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input word got, input word exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_line(input line got, input line exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_be(input line_be got, input line_be exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got %b expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_ring(input ring_req got, input ring_req exp);
		if (got !== exp) begin
			$display("Error at %0t ns: out_left got %h expected %h", $time, got, exp);
			stop_run();
		end
	endtask

	function automatic int unsigned pick(input int unsigned n);
		return {$random(seed)} % n;
	endfunction

	function automatic line random_line();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic ring_req make_right();
		ring_req r;
		r.ttl      = 2'(pick(4));
		r.read     = pick(2) == 1;
		r.inval    = pick(2) == 1;
		r.reply    = pick(2) == 1;
		r.addr.raw = $random(seed);
		if (r.ttl == TTL_MAX && !r.read && !r.inval)
			r.read = 1'b1; // new requests ask for something.
		return r;
	endfunction

	function automatic ring_req make_left();
		ring_req r;
		r = make_right();
		if (r.ttl == TTL_END && !injected)
			r.ttl = 2'd1; // no round trip without an injection.
		return r;
	endfunction

	task automatic track_extremes(inout hword mn, inout hword mx, input hword v);
		if (mn == '0 || v < mn)
			mn = v;
		if (v >= mx)
			mx = v;
	endtask

	task automatic clear_model();
		m_reads            = '0;
		m_writes           = '0;
		m_io_reads         = '0;
		m_io_writes        = '0;
		m_forwards         = '0;
		m_replies          = '0;
		m_ring_reads       = '0;
		m_ring_invals      = '0;
		m_ring_read_invals = '0;
		rd_min             = '0;
		rd_max             = '0;
		wr_min             = '0;
		wr_max             = '0;
		rg_min             = '0;
		rg_max             = '0;
	endtask

	function automatic word window_value(input logic [3:0] a);
		case (a)
			4'd0:    return m_reads;
			4'd1:    return m_writes;
			4'd2:    return {rd_max, rd_min};
			4'd3:    return {wr_max, wr_min};
			4'd4:    return m_ring_reads;
			4'd5:    return m_ring_invals;
			4'd6:    return m_ring_read_invals;
			4'd7:    return m_replies;
			4'd8:    return m_forwards;
			4'd9:    return {rg_max, rg_min};
			4'd10:   return m_io_reads;
			4'd11:   return m_io_writes;
			default: return '0;
		endcase
	endfunction

	// ******************************
	// stimulus and checking
	// ******************************
	task automatic drive_inputs(input bit fresh, input bit clr, input logic [3:0] win);
		bit start, wr;
		line_ptr addr;
		if (!(in_right_valid && !r_take)) begin
			in_right_valid <= fresh && pick(2) == 1;
			in_right       <= make_right();
		end
		if (!(in_left_valid && !l_take)) begin
			in_left_valid <= fresh && pick(2) == 1;
			in_left       <= make_left();
		end
		out_left_ready <= pick(4) != 0;
		if (!((local_read || local_write) && !mem_done)) begin
			start = fresh && pick(3) == 0;
			wr    = pick(2) == 1;
			addr  = 28'($random(seed));
			if (pick(4) != 0)
				addr[27:26] = IO_CACHED; // mostly cached lines.
			local_read       <= start && !wr;
			local_write      <= start && wr;
			local_address    <= addr;
			local_writedata  <= random_line();
			local_byteenable <= 16'($random(seed));
		end
		mem_waitrequest <= pick(2) == 1;
		mem_readdata    <= random_line();
		clear           <= clr;
		address         <= win;
	endtask

	task automatic observe();
		logic free;
		hword cyc;
		ring_addr a;
		free = (out_q.size() == 0) || out_left_ready;
		check_bit(in_right_ready, free, "in_right_ready");
		check_bit(in_left_ready, free && !in_right_valid, "in_left_ready");
		check_bit(out_left_valid, out_q.size() != 0, "out_left_valid");
		if (out_q.size() != 0)
			check_ring(out_left, out_q[0]);
		if (out_left_valid && out_left_ready)
			void'(out_q.pop_front());
		r_take = in_right_valid && free;
		l_take = in_left_valid && free && !in_right_valid;
		if (r_take)
			out_q.push_back(in_right);
		else if (l_take)
			out_q.push_back(in_left);

		if (l_take && in_left.ttl == TTL_END) begin
			if (in_left.reply)
				m_replies = m_replies + 1;
			track_extremes(rg_min, rg_max, ring_cnt);
		end
		if (r_take && in_right.ttl == TTL_MAX) begin
			m_ring_reads       = m_ring_reads + word'(in_right.read && !in_right.inval);
			m_ring_invals      = m_ring_invals + word'(!in_right.read && in_right.inval);
			m_ring_read_invals = m_ring_read_invals + word'(in_right.read && in_right.inval);
			injected = 1'b1;
			ring_cnt = 16'd1;
		end else begin
			if (r_take)
				m_forwards = m_forwards + 1;
			ring_cnt = ring_cnt + 16'd1;
		end

		a.raw = {local_address, 4'h0};
		check_word(mem_address, a.raw, "mem_address");
		check_bit(mem_read, local_read, "mem_read");
		check_bit(mem_write, local_write, "mem_write");
		check_bit(local_waitrequest, mem_waitrequest, "local_waitrequest");
		check_line(mem_writedata, local_writedata, "mem_writedata");
		check_line(local_readdata, mem_readdata, "local_readdata");
		check_be(mem_byteenable, local_byteenable, "mem_byteenable");
		mem_done = (local_read || local_write) && !mem_waitrequest;
		if (local_read || local_write) begin
			cyc = mem_cnt + 16'd1;
			if (mem_done) begin
				if (a.bits.io != IO_CACHED && local_write)
					m_io_writes = m_io_writes + 1;
				else if (a.bits.io != IO_CACHED)
					m_io_reads = m_io_reads + 1;
				else if (local_write) begin
					m_writes = m_writes + 1;
					track_extremes(wr_min, wr_max, cyc);
				end else begin
					m_reads = m_reads + 1;
					track_extremes(rd_min, rd_max, cyc);
				end
				mem_cnt = '0;
			end else begin
				mem_cnt = cyc;
			end
		end
		if (clear)
			clear_model(); // clear beats same-cycle events.
	endtask

	task automatic cycle(input bit fresh, input logic [3:0] win, input bit clr);
		@(posedge clk);
		drive_inputs(fresh, clr, win);
		@(negedge clk);
		check_word(readdata, window_value(address), "readdata");
		observe();
	endtask

	task automatic drain();
		bit busy;
		busy = 1'b1;
		while (busy) begin
			cycle(1'b0, 4'(pick(16)), 1'b0);
			busy = out_q.size() != 0 || (in_right_valid && !r_take) ||
			       (in_left_valid && !l_take) || ((local_read || local_write) && !mem_done);
		end
	endtask

	task automatic read_all_zero(input string when);
		for (int a = 0; a < 16; a++) begin
			cycle(1'b0, 4'(a), 1'b0);
			check_word(readdata, '0, when);
		end
	endtask

	always @(posedge clk) begin
		tick <= tick + 1;
		if (tick >= LIMIT) begin
			$display("Timeout: run went past %0d cycles", LIMIT);
			stop_run();
		end
	end

	initial begin
		in_left_valid    = 1'b0;
		in_right_valid   = 1'b0;
		out_left_ready   = 1'b0;
		in_left          = '0;
		in_right         = '0;
		local_address    = '0;
		local_read       = 1'b0;
		local_write      = 1'b0;
		local_writedata  = '0;
		local_byteenable = '0;
		mem_waitrequest  = 1'b0;
		mem_readdata     = '0;
		clear            = 1'b0;
		address          = '0;
		r_take           = 1'b0;
		l_take           = 1'b0;
		mem_done         = 1'b0;
		injected         = 1'b0;
		mem_cnt          = '0;
		ring_cnt         = '0;
		clear_model();
		wait (rst_n === 1'b1);

		read_all_zero("window after reset");
		repeat (WARM_CYCLES) cycle(1'b1, 4'(pick(16)), 1'b0);
		drain();
		cycle(1'b0, 4'd0, 1'b1);
		read_all_zero("window after clear");

		repeat (RAND_CYCLES) cycle(1'b1, 4'(pick(16)), pick(800) == 0);
		drain();
		for (int a = 0; a < 16; a++)
			cycle(1'b0, 4'(a), 1'b0); // final window sweep.

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
logic/perf_pkg.sv
logic/snoop_if.sv
logic/perf_snoop.sv
logic/perf_latency.sv
logic/perf_link.sv
verif/perf_clock.sv
verif/perf_link_assert.sv
verif/perf_link_tb.sv
